// ==== fb_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_mem (
  input  logic                                  core_clk,
  input  logic                                  wr_en,
  input  logic [hdmi_loop_pkg::ADDR_BITS-1:0]   wr_addr,
  input  logic [hdmi_loop_pkg::PIX565_BITS-1:0] wr_data,
  input  logic [hdmi_loop_pkg::ADDR_BITS-1:0]   rd_addr,
  output logic [hdmi_loop_pkg::PIX565_BITS-1:0] rd_data
);
  import hdmi_loop_pkg::*;

  logic [PIX565_BITS-1:0] mem [FRAME_PIXELS];  // one rgb565 frame

  always_ff @(posedge core_clk)
  begin
    if (wr_en)
      mem[wr_addr] <= wr_data;  // write port
    rd_data <= mem[rd_addr];    // registered read, 1 clock
  end

endmodule

`default_nettype wire

// ==== fb_read_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_read_ctrl (
  input  logic                                  core_clk,
  input  logic                                  rst_in,
  input  logic                                  raw_hs,
  input  logic                                  raw_vs,
  input  logic                                  rd_req,
  input  logic                                  frame_valid,
  output logic [hdmi_loop_pkg::ADDR_BITS-1:0]   rd_addr,
  input  logic [hdmi_loop_pkg::PIX565_BITS-1:0] rd_data,
  output logic                                  hs_out,
  output logic                                  vs_out,
  output logic                                  de_out,
  output logic [hdmi_loop_pkg::COLOR_BITS-1:0]  r_out,
  output logic [hdmi_loop_pkg::COLOR_BITS-1:0]  g_out,
  output logic [hdmi_loop_pkg::COLOR_BITS-1:0]  b_out
);
  import hdmi_loop_pkg::*;

  rd_state_t state;
  logic      hs_d1;  // first delay stage
  logic      vs_d1;
  logic      de_d1;  // lines up with rd_data
  logic      pix_on;

  assign pix_on = de_d1 && (state == RD_SHOW);

  ////////////////////
  // address and display state
  ////////////////////
  always_ff @(posedge core_clk)
  begin
    if (!rst_in)
    begin
      rd_addr <= '0;
      state   <= RD_BLANK;
    end
    else
    begin
      if (raw_vs)
        rd_addr <= '0;  // rewind each frame
      else if (rd_req)
        rd_addr <= rd_addr + 1'b1;
      if (state == RD_BLANK && raw_vs && frame_valid)
        state <= RD_SHOW;  // switch only inside vsync
    end
  end

  ////////////////////
  // two-stage output pipe
  ////////////////////
  always_ff @(posedge core_clk)
  begin
    if (!rst_in)
    begin
      hs_d1  <= 1'b0;
      vs_d1  <= 1'b0;
      de_d1  <= 1'b0;
      hs_out <= 1'b0;
      vs_out <= 1'b0;
      de_out <= 1'b0;
      r_out  <= '0;
      g_out  <= '0;
      b_out  <= '0;
    end
    else
    begin
      hs_d1  <= raw_hs;  // matches memory read latency
      vs_d1  <= raw_vs;
      de_d1  <= rd_req;
      hs_out <= hs_d1;
      vs_out <= vs_d1;
      de_out <= de_d1;
      // zero-fill low bits back to 8
      r_out  <= pix_on ? {rd_data[15:11], 3'b000} : '0;
      g_out  <= pix_on ? {rd_data[10:5], 2'b00}   : '0;
      b_out  <= pix_on ? {rd_data[4:0], 3'b000}   : '0;
    end
  end

endmodule

`default_nettype wire

// ==== fb_write_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module fb_write_ctrl (
  input  logic                                  core_clk,
  input  logic                                  rst_in,
  input  logic                                  vs_in,
  input  logic                                  de_in,
  input  logic [hdmi_loop_pkg::COLOR_BITS-1:0]  r_in,
  input  logic [hdmi_loop_pkg::COLOR_BITS-1:0]  g_in,
  input  logic [hdmi_loop_pkg::COLOR_BITS-1:0]  b_in,
  output logic                                  wr_en,
  output logic [hdmi_loop_pkg::ADDR_BITS-1:0]   wr_addr,
  output logic [hdmi_loop_pkg::PIX565_BITS-1:0] wr_data,
  output logic                                  frame_valid
);
  import hdmi_loop_pkg::*;

  wr_state_t              state;
  logic [ADDR_BITS-1:0]   addr_cnt;    // next store slot
  logic                   frame_full;  // last slot taken this frame
  logic [PIX565_BITS-1:0] pix565;

  // keep top 5/6/5 bits
  assign pix565 = {r_in[COLOR_BITS-1 -: 5], g_in[COLOR_BITS-1 -: 6], b_in[COLOR_BITS-1 -: 5]};

  always_ff @(posedge core_clk)
  begin
    if (!rst_in)
    begin
      state       <= WR_WAIT_SYNC;
      addr_cnt    <= '0;
      frame_full  <= 1'b0;
      wr_en       <= 1'b0;
      frame_valid <= 1'b0;
    end
    else
    begin
      wr_en <= 1'b0;  // single-cycle strobe
      case (state)
        WR_WAIT_SYNC:
          if (vs_in)
            state <= WR_FILL;  // align to a frame start
        WR_FILL:
          if (vs_in)
          begin
            addr_cnt   <= '0;  // held at top of frame
            frame_full <= 1'b0;
          end
          else if (de_in && !frame_full)
          begin
            wr_en    <= 1'b1;
            addr_cnt <= addr_cnt + 1'b1;
            if (addr_cnt == ADDR_BITS'(FRAME_PIXELS - 1))
              frame_full <= 1'b1;  // drop the rest of this frame
          end
      endcase
      if (wr_en && wr_addr == ADDR_BITS'(FRAME_PIXELS - 1))
        frame_valid <= 1'b1;  // sticky, store keeps last full image
    end
  end

  // write payload, qualified by wr_en
  always_ff @(posedge core_clk)
  begin
    wr_addr <= addr_cnt;
    wr_data <= pix565;
  end

endmodule

`default_nettype wire

// ==== hdmi_frame_loop.f ====
hdmi_loop_pkg.sv
video_timing_gen.sv
fb_write_ctrl.sv
fb_mem.sv
fb_read_ctrl.sv
hdmi_frame_loop_top.sv
tb_hdmi_frame_loop.sv

// ==== hdmi_frame_loop_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module hdmi_frame_loop_top (
  input  logic                                 core_clk,
  input  logic                                 rst_in,
  input  logic                                 vs_in,
  input  logic                                 de_in,
  input  logic [hdmi_loop_pkg::COLOR_BITS-1:0] r_in,
  input  logic [hdmi_loop_pkg::COLOR_BITS-1:0] g_in,
  input  logic [hdmi_loop_pkg::COLOR_BITS-1:0] b_in,
  output logic                                 hs_out,
  output logic                                 vs_out,
  output logic                                 de_out,
  output logic [hdmi_loop_pkg::COLOR_BITS-1:0] r_out,
  output logic [hdmi_loop_pkg::COLOR_BITS-1:0] g_out,
  output logic [hdmi_loop_pkg::COLOR_BITS-1:0] b_out,
  output logic                                 frame_valid
);
  import hdmi_loop_pkg::*;

  logic                   raw_hs;
  logic                   raw_vs;
  logic                   rd_req;   // raster active area
  logic                   wr_en;
  logic [ADDR_BITS-1:0]   wr_addr;
  logic [PIX565_BITS-1:0] wr_data;
  logic [ADDR_BITS-1:0]   rd_addr;
  logic [PIX565_BITS-1:0] rd_data;

  ////////////////////
  // input side
  ////////////////////
  fb_write_ctrl u_wr (
    .core_clk    (core_clk),
    .rst_in      (rst_in),
    .vs_in       (vs_in),
    .de_in       (de_in),
    .r_in        (r_in),
    .g_in        (g_in),
    .b_in        (b_in),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .frame_valid (frame_valid)
  );

  fb_mem u_mem (
    .core_clk (core_clk),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

  ////////////////////
  // output side
  ////////////////////
  video_timing_gen u_tg (
    .core_clk (core_clk),
    .rst_in   (rst_in),
    .raw_hs   (raw_hs),
    .raw_vs   (raw_vs),
    .rd_req   (rd_req)
  );

  fb_read_ctrl u_rd (
    .core_clk    (core_clk),
    .rst_in      (rst_in),
    .raw_hs      (raw_hs),
    .raw_vs      (raw_vs),
    .rd_req      (rd_req),
    .frame_valid (frame_valid),
    .rd_addr     (rd_addr),
    .rd_data     (rd_data),
    .hs_out      (hs_out),
    .vs_out      (vs_out),
    .de_out      (de_out),
    .r_out       (r_out),
    .g_out       (g_out),
    .b_out       (b_out)
  );

endmodule

`default_nettype wire

// ==== hdmi_loop_pkg.sv ====
`default_nettype none

package hdmi_loop_pkg;

  ////////////////////
  // raster timing
  ////////////////////
  localparam int H_ACT   = 16;  // active clocks per line
  localparam int H_FP    = 2;   // front porch
  localparam int H_SYNC  = 3;   // hs pulse width
  localparam int H_BP    = 3;   // back porch
  localparam int H_TOTAL = 24;  // whole line

  localparam int V_ACT   = 8;   // active lines per frame
  localparam int V_FP    = 1;
  localparam int V_SYNC  = 2;   // vs width in lines
  localparam int V_BP    = 2;
  localparam int V_TOTAL = 13;  // whole frame

  localparam int X_BITS = 5;  // holds 0..H_TOTAL-1
  localparam int Y_BITS = 4;  // holds 0..V_TOTAL-1

  ////////////////////
  // pixel and store sizes
  ////////////////////
  localparam int COLOR_BITS   = 8;              // rgb888 channel
  localparam int PIX565_BITS  = 16;             // packed store word
  localparam int FRAME_PIXELS = H_ACT * V_ACT;  // 128 words
  localparam int ADDR_BITS    = 7;              // clog2 of frame size

  typedef enum logic
  {
    WR_WAIT_SYNC,  // idle until the first input vs
    WR_FILL        // taking pixels
  } wr_state_t;

  typedef enum logic
  {
    RD_BLANK,  // nothing complete yet, send black
    RD_SHOW    // store holds a full image
  } rd_state_t;

endpackage

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the hdmi_frame_loop testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_hdmi_frame_loop -f hdmi_frame_loop.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vtb_hdmi_frame_loop > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "All tests passed" sim.log; then
  exit 0
fi
echo "pass message not found in sim.log"
exit 1

// ==== tb_hdmi_frame_loop.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_hdmi_frame_loop;
  import hdmi_loop_pkg::*;

  localparam int          CLK_NS     = 100;
  localparam logic [31:0] SEED       = 32'hc14c24c9;
  localparam int          FRAME_CLKS = H_TOTAL * V_TOTAL;   // one output frame
  localparam int          WDOG_CLKS  = 5 * 8 * FRAME_CLKS;  // 8 frames for each of 5 tests

  logic                  core_clk;
  logic                  rst_in;
  logic                  vs_in;
  logic                  de_in;
  logic [COLOR_BITS-1:0] r_in;
  logic [COLOR_BITS-1:0] g_in;
  logic [COLOR_BITS-1:0] b_in;
  logic                  hs_out;
  logic                  vs_out;
  logic                  de_out;
  logic                  frame_valid;
  logic [COLOR_BITS-1:0] r_out;
  logic [COLOR_BITS-1:0] g_out;
  logic [COLOR_BITS-1:0] b_out;

  logic [31:0] rng_state;
  logic [23:0] sent [$];  // rgb888 inputs in raster order
  int          errors;
  int          checks;

  hdmi_frame_loop_top dut0 (.*);

  initial
  begin
    core_clk = 1'b0;
    forever #(CLK_NS / 2) core_clk = ~core_clk;
  end

  initial
  begin
    #(WDOG_CLKS * CLK_NS);
    $display("watchdog expired after %0d clocks, checks %0d, errors %0d",
             WDOG_CLKS, checks, errors);
    $display("Some tests failed");
    $finish;
  end

  ////////////////////
  // helpers
  ////////////////////
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [23:0] next_pixel();
    rng_state = xorshift32(rng_state);
    return rng_state[23:0];
  endfunction

  task automatic next_clock();
    @(posedge core_clk);
    #10;  // drive and sample clear of the edge
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
    else
    begin
      errors++;
      $display("MISMATCH %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic check_black();
    check_value("r_out", 32'(r_out), 32'd0);
    check_value("g_out", 32'(g_out), 32'd0);
    check_value("b_out", 32'(b_out), 32'd0);
  endtask

  task automatic apply_reset();
    rst_in = 1'b0;
    vs_in  = 1'b0;
    de_in  = 1'b0;
    repeat (2) next_clock();
    rst_in = 1'b1;
  endtask

  task automatic send_vsync();
    vs_in = 1'b1;
    de_in = 1'b0;
    repeat (3) next_clock();  // arms writer then rewinds address
    vs_in = 1'b0;
  endtask

  // one input frame with random de_in gaps carrying junk data
  task automatic send_frame(input int npix);
    logic [23:0] gap;
    sent.delete();
    send_vsync();
    for (int i = 0; i < npix; i++)
    begin
      gap = next_pixel();
      de_in = 1'b0;
      repeat (gap[1:0])
      begin
        {r_in, g_in, b_in} = next_pixel();  // must never be stored
        next_clock();
      end
      {r_in, g_in, b_in} = next_pixel();
      de_in = 1'b1;
      sent.push_back({r_in, g_in, b_in});
      next_clock();
    end
    de_in = 1'b0;
    next_clock();  // write of last pixel lands here
  endtask

  task automatic watch_black(input int nclks, output int de_cnt);
    de_cnt = 0;
    repeat (nclks)
    begin
      next_clock();
      check_value("frame_valid", 32'(frame_valid), 32'd0);
      check_black();  // no full frame stored yet
      if (de_out)
        de_cnt++;
    end
  endtask

  // skip any pulse in progress so the switch to live video is seen whole
  task automatic wait_show();
    while (!frame_valid) next_clock();
    while (vs_out) next_clock();
    while (!vs_out) next_clock();
    while (vs_out) next_clock();
  endtask

  task automatic check_frame();
    int          n;
    logic [23:0] exp;
    n = 0;
    while (n < FRAME_PIXELS)
    begin
      next_clock();
      if (de_out)
      begin
        exp = sent[n] & 24'hf8fcf8;  // 5/6/5 msbs kept with low bits zero
        check_value($sformatf("r_out pixel %0d", n), 32'(r_out), 32'(exp[23:16]));
        check_value($sformatf("g_out pixel %0d", n), 32'(g_out), 32'(exp[15:8]));
        check_value($sformatf("b_out pixel %0d", n), 32'(b_out), 32'(exp[7:0]));
        n++;
      end
      else
      begin
        check_black();  // blanking carries no color
      end
    end
  endtask

  ////////////////////
  // tests
  ////////////////////
  task automatic test_idle_black();
    int n;
    int de_cnt;
    apply_reset();
    n = 0;
    while (!de_out)
    begin
      next_clock();
      n++;
    end
    check_value("first de_out delay", n, 3);  // raster register plus 2 pipe stages
    watch_black(FRAME_CLKS, de_cnt);
    check_value("de_out clocks per frame", de_cnt, FRAME_PIXELS);
  endtask

  task automatic test_raster_timing();
    int   t;
    int   t_de;
    int   t_hs;
    int   t_vs;
    int   lines;
    int   vs_rises;
    logic de_q;
    logic hs_q;
    logic vs_q;
    apply_reset();
    t_de = -1;
    t_hs = -1;
    t_vs = -1;
    lines = 0;
    vs_rises = 0;
    {de_q, hs_q, vs_q} = 3'b000;
    for (t = 0; t < 3 * FRAME_CLKS; t++)
    begin
      next_clock();
      if (de_out && !de_q)
      begin
        t_de = t;
        lines++;
      end
      if (!de_out && de_q) check_value("de_out width", t - t_de, H_ACT);
      if (hs_out && !hs_q)
      begin
        if (t_hs >= 0) check_value("line length", t - t_hs, H_TOTAL);
        if (t_de >= 0 && t - t_de < H_TOTAL) check_value("de to hs", t - t_de, H_ACT + H_FP);
        t_hs = t;
      end
      if (!hs_out && hs_q) check_value("hs_out width", t - t_hs, H_SYNC);
      if (vs_out && !vs_q)
      begin
        check_value("de lines per frame", lines, V_ACT);
        if (t_vs >= 0) check_value("frame length", t - t_vs, FRAME_CLKS);
        lines = 0;
        t_vs = t;
        vs_rises++;
      end
      if (!vs_out && vs_q) check_value("vs_out width", t - t_vs, V_SYNC * H_TOTAL);
      {de_q, hs_q, vs_q} = {de_out, hs_out, vs_out};
    end
    check_value("vs_out pulses", vs_rises, 3);
  endtask

  // junk in the de_in gaps must not shift pixels
  task automatic test_loop_through();
    apply_reset();
    send_frame(FRAME_PIXELS);
    check_value("frame_valid after last write", 32'(frame_valid), 32'd1);
    wait_show();
    check_frame();
  endtask

  task automatic test_partial_frame();
    int de_cnt;
    apply_reset();
    send_frame(FRAME_PIXELS - 28);
    send_vsync();  // next frame starts before the store is full
    watch_black(2 * FRAME_CLKS, de_cnt);
    check_value("de_out clocks in 2 frames", de_cnt, 2 * FRAME_PIXELS);
  endtask

  task automatic test_overlong_frame();
    apply_reset();
    send_frame(FRAME_PIXELS + 5);  // extra 5 dropped
    wait_show();
    check_frame();
  endtask

  initial
  begin
    rng_state = SEED;
    errors    = 0;
    checks    = 0;
    rst_in    = 1'b0;
    vs_in     = 1'b0;
    de_in     = 1'b0;
    {r_in, g_in, b_in} = '0;
    test_idle_black();
    test_raster_timing();
    test_loop_through();
    test_partial_frame();
    test_overlong_frame();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== video_timing_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_timing_gen (
  input  logic core_clk,
  input  logic rst_in,
  output logic raw_hs,
  output logic raw_vs,
  output logic rd_req
);
  import hdmi_loop_pkg::*;

  logic [X_BITS-1:0] h_cnt;  // pixel within line
  logic [Y_BITS-1:0] v_cnt;  // line within frame
  logic              h_last;
  logic              v_last;

  assign h_last = (h_cnt == X_BITS'(H_TOTAL - 1));  // end of line
  assign v_last = (v_cnt == Y_BITS'(V_TOTAL - 1));  // last line of frame

  ////////////////////
  // raster counters
  ////////////////////
  always_ff @(posedge core_clk)
  begin
    if (!rst_in)
    begin
      h_cnt <= '0;  // 0 is first active pixel
      v_cnt <= '0;
    end
    else
    begin
      if (h_last)
      begin
        h_cnt <= '0;
        if (v_last)
          v_cnt <= '0;  // new frame
        else
          v_cnt <= v_cnt + 1'b1;
      end
      else
      begin
        h_cnt <= h_cnt + 1'b1;
      end
    end
  end

  ////////////////////
  // decoded syncs, one clock behind counters
  ////////////////////
  // line order is active, front porch, sync, back porch; same for lines
  always_ff @(posedge core_clk)
  begin
    if (!rst_in)
    begin
      raw_hs <= 1'b0;
      raw_vs <= 1'b0;
      rd_req <= 1'b0;
    end
    else
    begin
      rd_req <= (h_cnt < X_BITS'(H_ACT)) && (v_cnt < Y_BITS'(V_ACT));  // active area
      raw_hs <= (h_cnt >= X_BITS'(H_ACT + H_FP)) &&
                (h_cnt <  X_BITS'(H_ACT + H_FP + H_SYNC));  // active high
      raw_vs <= (v_cnt >= Y_BITS'(V_ACT + V_FP)) &&
                (v_cnt <  Y_BITS'(V_ACT + V_FP + V_SYNC));  // whole lines
    end
  end

endmodule

`default_nettype wire
